//--- all.f
source/bip_isa_pkg.sv
source/bip_mem_pkg.sv
source/bip_fetch.sv
source/bip_control.sv
source/bip_datapath.sv
source/bip_data_mem.sv
source/bip_top.sv
testbench/bip_props.sv
testbench/bip_tb.sv

//--- testbench/bip_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bip_tb;

  localparam int CLOCK_PERIOD    = 100;
  localparam int NUM_ROWS        = 8;
  localparam int NUM_RANDOM      = 20;
  localparam int HALT_LIMIT      = 32;  // Cycles allowed per program.
  localparam int WATCHDOG_CYCLES = (NUM_ROWS + NUM_RANDOM) * 40;
  localparam logic [15:0] HALT   = {bip_isa_pkg::HLT, 11'h000};

  logic                                    i_clock;
  logic                                    i_reset;
  logic                                    i_run;
  logic                                    i_prog_we;
  logic [bip_mem_pkg::PROG_ADDR_WIDTH-1:0] i_prog_addr;
  logic [bip_isa_pkg::INSTR_WIDTH-1:0]     i_prog_data;
  logic [bip_mem_pkg::DATA_ADDR_WIDTH-1:0] i_dbg_addr;
  wire  [bip_isa_pkg::DATA_WIDTH-1:0]      o_dbg_data;
  wire  [bip_isa_pkg::DATA_WIDTH-1:0]      o_acc;
  wire  [bip_mem_pkg::PROG_ADDR_WIDTH-1:0] o_pc;
  wire                                     o_halt;

  ////////////////////
  // Program table.
  ////////////////////

  logic [0:7][15:0] tab_prog  [NUM_ROWS];  // Program words, HLT padded.
  int               tab_halt  [NUM_ROWS];  // Address of the HLT.
  int               tab_pause [NUM_ROWS];  // Run-low pause point, 0 for none.
  logic [15:0]      tab_acc   [NUM_ROWS];
  logic [5:0]       tab_addr  [NUM_ROWS];  // Inspected data word.
  logic [15:0]      tab_word  [NUM_ROWS];
  logic [15:0]      model_mem [64];        // Reference data memory.
  int               errors = 0;
  int               checks = 0;

  bip_top UUT (
    .i_clock(i_clock), .i_reset(i_reset), .i_run(i_run), .i_prog_we(i_prog_we),
    .i_prog_addr(i_prog_addr), .i_prog_data(i_prog_data), .i_dbg_addr(i_dbg_addr),
    .o_dbg_data(o_dbg_data), .o_acc(o_acc), .o_pc(o_pc), .o_halt(o_halt)
  );

  initial begin
    i_clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) i_clock = ~i_clock;
  end

  function automatic logic [15:0] encode(bip_isa_pkg::opcode_e op, logic [10:0] operand);
    return {op, operand};
  endfunction

  function automatic logic [15:0] sext(logic [10:0] v);
    return {{5{v[10]}}, v};  // Operand sign fills the top.
  endfunction

  task automatic set_row(input int r, input logic [0:7][15:0] prog, input int halt_at,
                         input int pause_at, input logic [15:0] acc,
                         input logic [5:0] addr, input logic [15:0] word);
    tab_prog[r]  = prog;
    tab_halt[r]  = halt_at;
    tab_pause[r] = pause_at;
    tab_acc[r]   = acc;
    tab_addr[r]  = addr;
    tab_word[r]  = word;
  endtask

  task automatic fill_table();
    set_row(0, {encode(bip_isa_pkg::LDI, 11'h7F0), {7{HALT}}},
            1, 0, 16'hFFF0, 6'd5, 16'h0000);  // Negative immediate, unwritten word.
    set_row(1, {encode(bip_isa_pkg::LDI, 11'h7FF), encode(bip_isa_pkg::ADDI, 11'd2),
                encode(bip_isa_pkg::STO, 11'd3), {5{HALT}}},
            3, 0, 16'h0001, 6'd3, 16'h0001);  // Wraps past 16'hFFFF.
    set_row(2, {encode(bip_isa_pkg::LDI, 11'd3), encode(bip_isa_pkg::SUBI, 11'd5),
                encode(bip_isa_pkg::STO, 11'd10), encode(bip_isa_pkg::SUB, 11'd10),
                encode(bip_isa_pkg::SUBI, 11'd1), {3{HALT}}},
            5, 0, 16'hFFFF, 6'd10, 16'hFFFE);  // Below zero.
    set_row(3, {encode(bip_isa_pkg::LDI, 11'h123), encode(bip_isa_pkg::STO, 11'd4),
                encode(bip_isa_pkg::LDI, 11'd0), encode(bip_isa_pkg::LD, 11'd4),
                encode(bip_isa_pkg::ADD, 11'd4), encode(bip_isa_pkg::STO, 11'd9),
                {2{HALT}}},
            6, 0, 16'h0246, 6'd9, 16'h0246);
    set_row(4, {encode(bip_isa_pkg::LDI, 11'h2AA), encode(bip_isa_pkg::STO, 11'd20),
                encode(bip_isa_pkg::LDI, 11'h555), encode(bip_isa_pkg::STO, 11'd21),
                encode(bip_isa_pkg::LD, 11'd20), encode(bip_isa_pkg::SUB, 11'd21),
                {2{HALT}}},
            6, 3, 16'h0555, 6'd21, 16'hFD55);  // Round trip with a pause.
    set_row(5, {encode(bip_isa_pkg::LDI, 11'h400), encode(bip_isa_pkg::STO, 11'd2),
                encode(bip_isa_pkg::ADD, 11'd2), encode(bip_isa_pkg::ADD, 11'd2),
                encode(bip_isa_pkg::SUBI, 11'h400), {3{HALT}}},
            5, 2, 16'hF800, 6'd63, 16'h0000);
    set_row(6, {8{HALT}}, 0, 0, 16'h0000, 6'd0, 16'h0000);  // Halt at once.
    set_row(7, {encode(bip_isa_pkg::LDI, 11'd1), encode(bip_isa_pkg::ADDI, 11'd1),
                encode(bip_isa_pkg::ADDI, 11'd1), encode(bip_isa_pkg::STO, 11'd7),
                encode(bip_isa_pkg::ADD, 11'd7), encode(bip_isa_pkg::SUBI, 11'd2),
                encode(bip_isa_pkg::ADDI, 11'h7FF), HALT},
            7, 0, 16'h0003, 6'd7, 16'h0003);  // Full eight words.
  endtask

  task automatic check_word(input string what, input logic [15:0] got,
                            input logic [15:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // Reset held for 16 edges, long enough to clear the data RAM.
  task automatic apply_reset();
    @(posedge i_clock);
    #5;
    i_reset = 1'b0;
    i_run   = 1'b0;
    repeat (16) @(posedge i_clock);
    #5;
    i_reset = 1'b1;
  endtask

  task automatic load_program(input logic [0:7][15:0] prog, input int count);
    for (int i = 0; i < count; i++) begin
      @(posedge i_clock);
      #5;
      i_prog_we   = 1'b1;
      i_prog_addr = i[5:0];
      i_prog_data = prog[i];
    end
    @(posedge i_clock);  // Last word written here.
    #5;
    i_prog_we = 1'b0;
  endtask

  ////////////////////
  // Run and model.
  ////////////////////

  task automatic run_program(input int pause_at, output int edges, output bit halted);
    int          waited;
    logic [5:0]  pc_hold;
    logic [15:0] acc_hold;
    edges  = 0;
    waited = 0;
    halted = 1'b0;
    i_run  = 1'b1;
    while (!halted && waited < HALT_LIMIT) begin
      @(posedge i_clock);
      #5;
      waited++;
      if (i_run) edges++;  // Only edges that executed.
      if (o_halt) begin
        halted = 1'b1;
      end
      else if (pause_at > 0 && edges == pause_at && i_run) begin
        i_run    = 1'b0;
        pc_hold  = o_pc;
        acc_hold = o_acc;
        repeat (4) @(posedge i_clock);
        #5;
        check_word("o_pc during pause", 16'(o_pc), 16'(pc_hold));
        check_word("o_acc during pause", o_acc, acc_hold);
        i_run = 1'b1;
      end
    end
  endtask

  task automatic run_model(input logic [0:7][15:0] prog, input int count,
                           output logic [15:0] acc);
    logic [5:0] addr;
    acc = '0;
    for (int i = 0; i < 64; i++) model_mem[i] = '0;
    for (int i = 0; i < count; i++) begin
      addr = prog[i][5:0];  // Low operand bits address data.
      case (prog[i][15:11])
        bip_isa_pkg::STO:  model_mem[addr] = acc;
        bip_isa_pkg::LD:   acc = model_mem[addr];
        bip_isa_pkg::LDI:  acc = sext(prog[i][10:0]);
        bip_isa_pkg::ADD:  acc = acc + model_mem[addr];
        bip_isa_pkg::ADDI: acc = acc + sext(prog[i][10:0]);
        bip_isa_pkg::SUB:  acc = acc - model_mem[addr];
        bip_isa_pkg::SUBI: acc = acc - sext(prog[i][10:0]);
        default: ;
      endcase
    end
  endtask

  task automatic execute_test(input int idx, input logic [0:7][15:0] prog,
                              input int halt_at, input int pause_at,
                              input logic [15:0] exp_acc, input logic [5:0] addr,
                              input logic [15:0] exp_word);
    int          edges;
    bit          halted;
    int          errors_before;
    logic [5:0]  pc_hold;
    logic [15:0] acc_hold;
    errors_before = errors;
    apply_reset();
    check_word("o_pc after reset", 16'(o_pc), 16'h0000);
    check_word("o_acc after reset", o_acc, 16'h0000);
    check_word("o_halt after reset", 16'(o_halt), 16'h0000);
    load_program(prog, halt_at + 1);
    run_program(pause_at, edges, halted);
    if (!halted) begin
      $display("Test %0d: o_halt never arrived within %0d cycles.", idx, HALT_LIMIT);
      errors++;
    end
    else begin
      check_word("edges to halt", 16'(edges), 16'(halt_at + 1));  // N+1 rule.
      check_word("o_pc at halt", 16'(o_pc), 16'(halt_at));
      check_word("o_acc", o_acc, exp_acc);
      pc_hold  = o_pc;
      acc_hold = o_acc;
      repeat (2) @(posedge i_clock);
      #5;
      check_word("o_pc after halt", 16'(o_pc), 16'(pc_hold));
      check_word("o_acc after halt", o_acc, acc_hold);
    end
    i_run      = 1'b0;
    i_dbg_addr = addr;
    #1;
    check_word("o_dbg_data", o_dbg_data, exp_word);
    $display("Test %0d: %s", idx, (errors == errors_before) ? "ok" : "failed");
  endtask

  ////////////////////
  // Main sequence.
  ////////////////////

  initial begin
    logic [0:7][15:0]     words;
    bip_isa_pkg::opcode_e op;
    logic [10:0]          operand;
    logic [15:0]          exp_acc;
    logic [5:0]           addr;
    i_reset     = 1'b0;
    i_run       = 1'b0;
    i_prog_we   = 1'b0;
    i_prog_addr = '0;
    i_prog_data = '0;
    i_dbg_addr  = '0;
    void'($urandom(32'h6347_c612));
    fill_table();
    for (int r = 0; r < NUM_ROWS; r++) begin
      execute_test(r, tab_prog[r], tab_halt[r], tab_pause[r], tab_acc[r],
                   tab_addr[r], tab_word[r]);
    end
    // Five random arithmetic and store instructions, then HLT.
    for (int t = 0; t < NUM_RANDOM; t++) begin
      words = {8{HALT}};
      for (int i = 0; i < 5; i++) begin
        op = bip_isa_pkg::opcode_e'(5'(1 + $urandom % 7));
        if (op inside {bip_isa_pkg::LDI, bip_isa_pkg::ADDI, bip_isa_pkg::SUBI})
          operand = 11'($urandom % 2048);
        else
          operand = 11'($urandom % 8);  // Few addresses, more reuse.
        words[i] = encode(op, operand);
      end
      run_model(words, 5, exp_acc);
      addr = 6'($urandom % 8);
      execute_test(NUM_ROWS + t, words, 5, 0, exp_acc, addr, model_mem[addr]);
    end
    $display("Tests: %0d, checks: %0d, errors: %0d, property failures: %0d",
             NUM_ROWS + NUM_RANDOM, checks, errors, UUT.u_props.fail_count);
    if (errors == 0 && UUT.u_props.fail_count == 0) begin
      $display("SIMULATION PASSED");
    end
    else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Ends a stuck run.
  initial begin
    #(WATCHDOG_CYCLES * CLOCK_PERIOD);
    $display("Watchdog expired: o_halt never arrived before the time limit.");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/bip_props.sv
`timescale 1ns/1ps
`default_nettype none

// Core invariants seen at the bip_top boundary.
module bip_props (
  input wire                                     i_clock,
  input wire                                     i_reset,
  input wire                                     i_run,
  input wire                                     i_acc_we,  // Control unit strobes.
  input wire                                     i_mem_we,
  input wire                                     i_halt,
  input wire [bip_mem_pkg::PROG_ADDR_WIDTH-1:0]  i_pc,
  input wire [bip_isa_pkg::DATA_WIDTH-1:0]       i_acc
);

  int fail_count = 0;  // Failure tally.

  // One write target per instruction.
  one_write: assert property (@(posedge i_clock) disable iff (!i_reset)
      !(i_acc_we && i_mem_we))
    else begin
      $error("Accumulator and data memory written in the same cycle.");
      fail_count++;
    end

  // Halted core is frozen until reset.
  halt_frozen: assert property (@(posedge i_clock) disable iff (!i_reset)
      i_halt |=> ($stable(i_pc) && $stable(i_acc)))
    else begin
      $error("PC or accumulator moved while halted.");
      fail_count++;
    end

  ////////////////////
  // Run gating.
  ////////////////////

  // A stalled core holds its PC and accumulator.
  run_gated: assert property (@(posedge i_clock) disable iff (!i_reset)
      !i_run |=> ($stable(i_pc) && $stable(i_acc)))
    else begin
      $error("PC or accumulator moved with i_run low.");
      fail_count++;
    end

endmodule

bind bip_top bip_props u_props (
  .i_clock  (i_clock),
  .i_reset  (i_reset),
  .i_run    (i_run),
  .i_acc_we (acc_we),
  .i_mem_we (mem_we),
  .i_halt   (o_halt),
  .i_pc     (o_pc),
  .i_acc    (o_acc)
);

`default_nettype wire

//--- source/bip_top.sv
`timescale 1ns/1ps
`default_nettype none

module bip_top (
  input  wire                                      i_clock,
  input  wire                                      i_reset,
  input  wire                                      i_run,
  input  wire                                      i_prog_we,
  input  wire  [bip_mem_pkg::PROG_ADDR_WIDTH-1:0]  i_prog_addr,
  input  wire  [bip_isa_pkg::INSTR_WIDTH-1:0]      i_prog_data,
  input  wire  [bip_mem_pkg::DATA_ADDR_WIDTH-1:0]  i_dbg_addr,
  output logic [bip_isa_pkg::DATA_WIDTH-1:0]       o_dbg_data,
  output logic [bip_isa_pkg::DATA_WIDTH-1:0]       o_acc,
  output logic [bip_mem_pkg::PROG_ADDR_WIDTH-1:0]  o_pc,
  output logic                                     o_halt
);

  ////////////////////
  // Internal nets.
  ////////////////////

  logic [bip_isa_pkg::INSTR_WIDTH-1:0]   instr;
  bip_isa_pkg::opcode_e                  opcode;
  logic [bip_isa_pkg::OPERAND_WIDTH-1:0] operand;
  bip_isa_pkg::acc_src_e                 acc_src;
  logic                                  sel_imm;
  logic                                  acc_we;
  logic                                  mem_we;
  logic                                  pc_en;
  logic [bip_isa_pkg::OPERAND_WIDTH-1:0] mem_addr;
  logic [bip_isa_pkg::DATA_WIDTH-1:0]    mem_rdata;

  // Instruction fields.
  assign opcode  = bip_isa_pkg::opcode_e'(
                     instr[bip_isa_pkg::INSTR_WIDTH-1 -: bip_isa_pkg::OPCODE_WIDTH]);
  assign operand = instr[bip_isa_pkg::OPERAND_WIDTH-1:0];

  bip_fetch u_fetch (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .i_pc_en     (pc_en),
    .i_prog_we   (i_prog_we),
    .i_prog_addr (i_prog_addr),
    .i_prog_data (i_prog_data),
    .o_instr     (instr),
    .o_pc        (o_pc)
  );

  bip_control u_control (
    .i_clock   (i_clock),
    .i_reset   (i_reset),
    .i_run     (i_run),
    .i_opcode  (opcode),
    .o_acc_src (acc_src),
    .o_sel_imm (sel_imm),
    .o_acc_we  (acc_we),
    .o_mem_we  (mem_we),
    .o_pc_en   (pc_en),
    .o_halt    (o_halt)
  );

  bip_datapath u_datapath (
    .i_clock    (i_clock),
    .i_reset    (i_reset),
    .i_acc_src  (acc_src),
    .i_sel_imm  (sel_imm),
    .i_acc_we   (acc_we),
    .i_opcode   (opcode),
    .i_operand  (operand),
    .i_mem_data (mem_rdata),
    .o_addr     (mem_addr),
    .o_acc      (o_acc)     // Also the store data.
  );

  bip_data_mem u_data_mem (
    .i_clock    (i_clock),
    .i_reset    (i_reset),
    .i_we       (mem_we),
    .i_addr     (mem_addr),
    .i_wdata    (o_acc),
    .o_rdata    (mem_rdata),
    .i_dbg_addr (i_dbg_addr),
    .o_dbg_data (o_dbg_data)
  );

endmodule

`default_nettype wire

//--- source/bip_data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module bip_data_mem (
  input  wire                                      i_clock,
  input  wire                                      i_reset,
  input  wire                                      i_we,        // STO strobe.
  input  wire  [bip_isa_pkg::OPERAND_WIDTH-1:0]    i_addr,
  input  wire  [bip_isa_pkg::DATA_WIDTH-1:0]       i_wdata,
  output logic [bip_isa_pkg::DATA_WIDTH-1:0]       o_rdata,
  input  wire  [bip_mem_pkg::DATA_ADDR_WIDTH-1:0]  i_dbg_addr,  // Inspection port.
  output logic [bip_isa_pkg::DATA_WIDTH-1:0]       o_dbg_data
);

  logic [bip_isa_pkg::DATA_WIDTH-1:0] ram [bip_mem_pkg::DATA_DEPTH];
  logic [bip_mem_pkg::DATA_ADDR_WIDTH-1:0] core_addr;  // Low operand bits.

  // Clear pointer, one group of words per reset cycle.
  logic [bip_mem_pkg::DATA_CLEAR_CNT_WIDTH-1:0] clr_cnt = '0;

  assign core_addr = i_addr[bip_mem_pkg::DATA_ADDR_WIDTH-1:0];

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      clr_cnt <= clr_cnt + 1'b1;  // Walks the RAM during reset.
    end
    else begin
      clr_cnt <= '0;  // Ready for the next reset.
    end
  end

  ////////////////////
  // RAM write side.
  ////////////////////

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      for (int k = 0; k < bip_mem_pkg::DATA_CLEAR_WORDS; k++) begin
        ram[bip_mem_pkg::DATA_CLEAR_WORDS * clr_cnt + k] <= '0;  // Zero a group.
      end
    end
    else if (i_we) begin
      ram[core_addr] <= i_wdata;
    end
  end

  // Both reads are combinational.
  assign o_rdata    = ram[core_addr];
  assign o_dbg_data = ram[i_dbg_addr];

endmodule

`default_nettype wire

//--- source/bip_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module bip_datapath (
  input  wire                                    i_clock,
  input  wire                                    i_reset,
  input  bip_isa_pkg::acc_src_e                  i_acc_src,   // Mux A select.
  input  wire                                    i_sel_imm,   // Mux B select.
  input  wire                                    i_acc_we,
  input  bip_isa_pkg::opcode_e                   i_opcode,
  input  wire  [bip_isa_pkg::OPERAND_WIDTH-1:0]  i_operand,
  input  wire  [bip_isa_pkg::DATA_WIDTH-1:0]     i_mem_data,  // Data RAM read word.
  output logic [bip_isa_pkg::OPERAND_WIDTH-1:0]  o_addr,
  output logic [bip_isa_pkg::DATA_WIDTH-1:0]     o_acc
);

  logic [bip_isa_pkg::DATA_WIDTH-1:0] acc;
  logic [bip_isa_pkg::DATA_WIDTH-1:0] imm_ext;  // Sign-extended operand.
  logic [bip_isa_pkg::DATA_WIDTH-1:0] mux_a;    // Accumulator input.
  logic [bip_isa_pkg::DATA_WIDTH-1:0] mux_b;    // ALU operand B.
  logic [bip_isa_pkg::DATA_WIDTH-1:0] alu_out;

  ////////////////////
  // Accumulator.
  ////////////////////

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      acc <= '0;
    end
    else if (i_acc_we) begin
      acc <= mux_a;  // Load or ALU result.
    end
  end

  // Replicate the operand sign bit.
  assign imm_ext = {{bip_isa_pkg::SIGN_EXT_WIDTH{i_operand[bip_isa_pkg::OPERAND_WIDTH-1]}},
                    i_operand};

  always_comb begin
    case (i_acc_src)
      bip_isa_pkg::SRC_MEM: mux_a = i_mem_data;
      bip_isa_pkg::SRC_IMM: mux_a = imm_ext;
      bip_isa_pkg::SRC_ALU: mux_a = alu_out;
      default:              mux_a = acc;  // Unused code keeps the value.
    endcase
  end

  assign mux_b = i_sel_imm ? imm_ext : i_mem_data;

  ////////////////////
  // Add/subtract unit.
  ////////////////////

  // Wraps modulo 2^16, no flags.
  always_comb begin
    case (i_opcode)
      bip_isa_pkg::ADD, bip_isa_pkg::ADDI: alu_out = acc + mux_b;
      bip_isa_pkg::SUB, bip_isa_pkg::SUBI: alu_out = acc - mux_b;
      default:                             alu_out = acc;  // Pass through.
    endcase
  end

  assign o_acc  = acc;        // Also the store data.
  assign o_addr = i_operand;  // Direct addressing.

endmodule

`default_nettype wire

//--- source/bip_control.sv
`timescale 1ns/1ps
`default_nettype none

module bip_control (
  input  wire                    i_clock,
  input  wire                    i_reset,
  input  wire                    i_run,      // Execute enable level.
  input  bip_isa_pkg::opcode_e   i_opcode,
  output bip_isa_pkg::acc_src_e  o_acc_src,  // Mux A select.
  output logic                   o_sel_imm,  // Mux B takes the immediate.
  output logic                   o_acc_we,
  output logic                   o_mem_we,
  output logic                   o_pc_en,
  output logic                   o_halt
);

  // Run state of the core.
  typedef enum logic {
    RUNNING = 1'b0,
    HALTED  = 1'b1
  } state_e;

  state_e state;
  state_e state_next;
  logic   active;     // Core may execute this cycle.
  logic   dec_acc_we; // Raw decode, before gating.
  logic   dec_mem_we;
  logic   dec_stop;

  ////////////////////
  // Decoder.
  ////////////////////

  always_comb begin
    o_acc_src  = bip_isa_pkg::SRC_ALU;  // Default source.
    o_sel_imm  = 1'b0;
    dec_acc_we = 1'b0;
    dec_mem_we = 1'b0;
    dec_stop   = 1'b0;
    case (i_opcode)
      bip_isa_pkg::HLT: dec_stop = 1'b1;
      bip_isa_pkg::STO: dec_mem_we = 1'b1;  // Store only.
      bip_isa_pkg::LD: begin
        o_acc_src  = bip_isa_pkg::SRC_MEM;
        dec_acc_we = 1'b1;
      end
      bip_isa_pkg::LDI: begin
        o_acc_src  = bip_isa_pkg::SRC_IMM;
        o_sel_imm  = 1'b1;
        dec_acc_we = 1'b1;
      end
      bip_isa_pkg::ADD, bip_isa_pkg::SUB: begin
        dec_acc_we = 1'b1;  // Memory operand.
      end
      bip_isa_pkg::ADDI, bip_isa_pkg::SUBI: begin
        o_sel_imm  = 1'b1;  // Immediate operand.
        dec_acc_we = 1'b1;
      end
      default: ;  // Unused codes act as no-ops.
    endcase
  end

  ////////////////////
  // Run/halt FSM.
  ////////////////////

  assign active = i_run && (state == RUNNING);

  always_comb begin
    state_next = state;
    if (active && dec_stop) begin
      state_next = HALTED;  // Held until reset.
    end
  end

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      state <= RUNNING;
    end
    else begin
      state <= state_next;
    end
  end

  // Strobes only while running with i_run high.
  assign o_acc_we = active && dec_acc_we;
  assign o_mem_we = active && dec_mem_we;
  assign o_pc_en  = active && !dec_stop;   // PC stays on HLT.
  assign o_halt   = (state == HALTED);

endmodule

`default_nettype wire

//--- source/bip_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module bip_fetch (
  input  wire                                      i_clock,
  input  wire                                      i_reset,
  input  wire                                      i_pc_en,      // Advance the PC.
  input  wire                                      i_prog_we,    // Load strobe.
  input  wire  [bip_mem_pkg::PROG_ADDR_WIDTH-1:0]  i_prog_addr,
  input  wire  [bip_isa_pkg::INSTR_WIDTH-1:0]      i_prog_data,
  output logic [bip_isa_pkg::INSTR_WIDTH-1:0]      o_instr,      // Word at the PC.
  output logic [bip_mem_pkg::PROG_ADDR_WIDTH-1:0]  o_pc
);

  ////////////////////
  // Program counter.
  ////////////////////

  logic [bip_mem_pkg::PROG_ADDR_WIDTH-1:0] pc;

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      pc <= '0;  // Start at address 0.
    end
    else if (i_pc_en) begin
      pc <= pc + 1'b1;  // Wraps at the top.
    end
  end

  assign o_pc = pc;

  ////////////////////
  // Program memory.
  ////////////////////

  // Contents come from the load port only.
  logic [bip_isa_pkg::INSTR_WIDTH-1:0] prog_mem [bip_mem_pkg::PROG_DEPTH];

  always_ff @(posedge i_clock) begin
    if (i_prog_we) begin
      prog_mem[i_prog_addr] <= i_prog_data;  // Written while stopped.
    end
  end

  // Asynchronous read at the PC.
  assign o_instr = prog_mem[pc];

endmodule

`default_nettype wire

//--- source/bip_mem_pkg.sv
`default_nettype none

// Memory sizing for program and data RAM.
package bip_mem_pkg;

  // Program memory.
  localparam int PROG_DEPTH      = 64;  // Instruction words.
  localparam int PROG_ADDR_WIDTH = 6;   // Also the PC width.

  // Data memory.
  localparam int DATA_DEPTH      = 64;  // Data words.
  localparam int DATA_ADDR_WIDTH = 6;   // Low operand bits used.

  // Reset clear of the data RAM, four words per cycle.
  localparam int DATA_CLEAR_WORDS     = 4;
  localparam int DATA_CLEAR_CNT_WIDTH = 4;  // 16 cycles cover the RAM.

endpackage

`default_nettype wire

//--- source/bip_isa_pkg.sv
`default_nettype none

////////////////////
// BIP I instruction set.
////////////////////

package bip_isa_pkg;

  // Instruction field widths.
  localparam int OPCODE_WIDTH  = 5;   // Upper bits of the word.
  localparam int OPERAND_WIDTH = 11;  // Immediate or data address.
  localparam int DATA_WIDTH    = 16;  // Accumulator and memory word.
  localparam int INSTR_WIDTH   = 16;  // Opcode plus operand.

  // Bits added by sign extension of the operand.
  localparam int SIGN_EXT_WIDTH = DATA_WIDTH - OPERAND_WIDTH;

  ////////////////////
  // Opcodes.
  ////////////////////

  typedef enum logic [OPCODE_WIDTH-1:0] {
    HLT  = 5'd0,  // Stop the core.
    STO  = 5'd1,  // mem[op] <= acc.
    LD   = 5'd2,  // acc <= mem[op].
    LDI  = 5'd3,  // acc <= sext(op).
    ADD  = 5'd4,  // acc <= acc + mem[op].
    ADDI = 5'd5,  // acc <= acc + sext(op).
    SUB  = 5'd6,  // acc <= acc - mem[op].
    SUBI = 5'd7   // acc <= acc - sext(op).
  } opcode_e;

  // Accumulator write source, mux A.
  typedef enum logic [1:0] {
    SRC_MEM = 2'd0,  // Data memory read word.
    SRC_IMM = 2'd1,  // Sign-extended operand.
    SRC_ALU = 2'd2   // Adder or subtractor result.
  } acc_src_e;

endpackage

`default_nettype wire
